/* project.f */
+incdir+bench
common/sniff_pkg.sv
sniff_checks/c0tx_read_checker.sv
sniff_checks/c1tx_mcl_checker.sv
sniff_checks/mmio_rsp_tracker.sv
verilog/err_fifo.sv
verilog/err_serializer.sv
verilog/ccip_sniffer.sv
bench/tb_ccip_sniffer.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_ccip_sniffer
FILELIST  := project.f
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Output goes to the console; status fails unless the pass line appears
run: build
	./$(OBJDIR)/V$(TOP) | awk '{ print } /^NO ERRORS$$/ { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* bench/sniff_ref.svh */
// ***********************************************************
// Reference model, expected error vector of one input cycle
// ***********************************************************
`ifndef SNIFF_REF_SVH
`define SNIFF_REF_SVH

// Channel 1 burst, beats still owed after the SOP beat
int        burst_left;
ccip_req_t burst_type;

// Outstanding MMIO reads, one entry per TID
bit        tid_active [MMIO_NUM_TIDS];
int        tid_timer  [MMIO_NUM_TIDS];

function automatic void clear_model();
   burst_left = 0;
   burst_type = WRLINE_I;
   for (int i = 0; i < MMIO_NUM_TIDS; i++) begin
      tid_active[i] = 1'b0;
      tid_timer[i]  = 0;
   end
endfunction

// Called once for every clock edge the DUT samples
function automatic sniff_vec_t expected_vector(input c0_req_t c0, input c1_req_t c1,
                                               input mmio_evt_t mq, input mmio_evt_t mr,
                                               input logic c0f, input logic c1f);
   sniff_vec_t v;
   bit         rd;
   bit         wr;
   bit         fence;
   v     = '0;
   rd    = c0.valid && ((c0.req_type == RDLINE_S) || (c0.req_type == RDLINE_I));
   wr    = c1.valid && ((c1.req_type == WRLINE_I) || (c1.req_type == WRLINE_M) ||
                        (c1.req_type == WRPUSH_I));
   fence = c1.valid && (c1.req_type == WRFENCE);

   // Channel 0, length and address only judged on reads
   if (c0.valid) begin
      v[C0TX_INVALID_REQTYPE] = !rd;
      v[C0TX_OVERFLOW]        = c0f;
   end
   if (rd) begin
      v[C0TX_3CL_REQUEST]    = (c0.cl_len == LEN_3CL);
      v[C0TX_ADDRALIGN_2]    = (c0.cl_len == LEN_2CL) && c0.address[0];
      v[C0TX_ADDRALIGN_4]    = (c0.cl_len == LEN_4CL) && (c0.address[1:0] != 2'b00);
      v[C0TX_ADDR_ZERO_WARN] = (c0.address == '0);
   end

   // Channel 1, fence is legal outside a burst
   if (c1.valid) begin
      v[C1TX_INVALID_REQTYPE] = !(wr || fence);
      v[C1TX_OVERFLOW]        = c1f;
   end
   if (burst_left == 0) begin
      if (wr) begin
         v[C1TX_SOP_NOT_SET]    = !c1.sop;
         v[C1TX_3CL_REQUEST]    = (c1.cl_len == LEN_3CL);
         v[C1TX_ADDRALIGN_2]    = (c1.cl_len == LEN_2CL) && c1.address[0];
         v[C1TX_ADDRALIGN_4]    = (c1.cl_len == LEN_4CL) && (c1.address[1:0] != 2'b00);
         v[C1TX_ADDR_ZERO_WARN] = (c1.address == '0);
         // Only a marked 2 or 4 line write opens a burst
         if (c1.sop && ((c1.cl_len == LEN_2CL) || (c1.cl_len == LEN_4CL))) begin
            burst_left = (c1.cl_len == LEN_2CL) ? 1 : 3;
            burst_type = c1.req_type;
         end
      end
   end else begin
      v[C1TX_SOP_SET_MCL1TO3]    = c1.valid && c1.sop;
      v[C1TX_WRFENCE_IN_MCL1TO3] = fence;
      v[C1TX_UNEXP_REQTYPE]      = wr && (c1.req_type != burst_type);
      if (wr) begin
         burst_left--;
      end
   end

   // MMIO, response judged against the table before this cycle
   v[MMIO_RDRSP_UNSOLICITED] = mr.valid && !tid_active[mr.tid];
   for (int i = 0; i < MMIO_NUM_TIDS; i++) begin
      if (mq.valid && (int'(mq.tid) == i)) begin
         tid_active[i] = 1'b1;
         tid_timer[i]  = 0;
      end else if (mr.valid && (int'(mr.tid) == i)) begin
         tid_active[i] = 1'b0;
         tid_timer[i]  = 0;
      end else if (tid_active[i] && (tid_timer[i] < MMIO_RSP_TIMEOUT)) begin
         tid_timer[i]++;
         // Flagged once, on reaching the limit
         if (tid_timer[i] == MMIO_RSP_TIMEOUT) begin
            v[MMIO_RDRSP_TIMEOUT] = 1'b1;
         end
      end
   end
   return v;
endfunction

`endif

/* bench/tb_ccip_sniffer.sv */
// ***********************************************************
// CCI-P sniffer testbench checking DUT codes against a model
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_ccip_sniffer
   import sniff_pkg::*;
();

   logic        clk = 1'b0;
   logic        ase_reset = 1'b1;
   c0_req_t     c0_req = '0;
   c1_req_t     c1_req = '0;
   mmio_evt_t   mmio_req = '0;
   mmio_evt_t   mmio_rsp = '0;
   logic        c0_full = 1'b0;
   logic        c1_full = 1'b0;
   logic        err_ready = 1'b0;
   logic        err_valid;
   sniff_code_t err_code;
   logic        lost_events;

   integer      seed = 92;
   int          errors = 0;
   int          checks = 0;
   // Vectors with codes not yet taken from the DUT
   int          vec_pending = 0;
   bit          timed_out = 1'b0;
   bit          hold_low = 1'b0;
   string       test_name = "reset";

   // Expected codes in output order
   sniff_code_t exp_code_q [$];
   bit          exp_last_q [$];
   string       exp_test_q [$];
   sniff_code_t exp_code;
   bit          exp_last;
   string       exp_test;
   bit          stalled = 1'b0;
   sniff_code_t stall_code;

   ccip_req_t   c0_types [5] = '{RDLINE_S, RDLINE_I, WRLINE_I, WRFENCE, ccip_req_t'(4'hF)};
   ccip_req_t   c1_types [5] = '{WRLINE_I, WRLINE_M, WRPUSH_I, WRFENCE, RDLINE_S};
   logic [CL_ADDR_WIDTH-1:0] c0_addrs [4] = '{42'h0, 42'h1, 42'h2, 42'h40};

   `include "sniff_ref.svh"

   ccip_sniffer u_dut (
      .clk         (clk),
      .ase_reset   (ase_reset),
      .c0_req      (c0_req),
      .c1_req      (c1_req),
      .mmio_req    (mmio_req),
      .mmio_rsp    (mmio_rsp),
      .c0_full     (c0_full),
      .c1_full     (c1_full),
      .err_ready   (err_ready),
      .err_valid   (err_valid),
      .err_code    (err_code),
      .lost_events (lost_events)
   );

   // 40 ns period
   always #20 clk = ~clk;

   // Random back-pressure with ready high about three cycles in four
   always @(posedge clk) begin
      if (ase_reset || hold_low) begin
         err_ready <= 1'b0;
      end else begin
         err_ready <= (($random(seed) & 3) != 0);
      end
   end

   function automatic int rnd(input int n);
      int r;
      r = $random(seed);
      return (r & 32'h7fff_ffff) % n;
   endfunction

   function automatic c0_req_t rd_req(input ccip_req_t t, input cl_len_t len,
                                      input logic [CL_ADDR_WIDTH-1:0] a);
      c0_req_t r;
      r.valid    = 1'b1;
      r.cl_len   = len;
      r.req_type = t;
      r.address  = a;
      return r;
   endfunction

   function automatic c1_req_t wr_req(input ccip_req_t t, input cl_len_t len, input logic sop,
                                      input logic [CL_ADDR_WIDTH-1:0] a);
      c1_req_t r;
      r.valid    = 1'b1;
      r.sop      = sop;
      r.cl_len   = len;
      r.req_type = t;
      r.address  = a;
      return r;
   endfunction

   function automatic mmio_evt_t evt(input logic valid, input logic [MMIO_TID_WIDTH-1:0] tid);
      mmio_evt_t e;
      e.valid = valid;
      e.tid   = tid;
      return e;
   endfunction

   // Splits a vector into codes in ascending index
   task automatic queue_codes(input sniff_vec_t v);
      int last;
      last = -1;
      for (int i = 0; i < SNIFF_NUM_CODES; i++) begin
         if (v[i]) begin
            last = i;
         end
      end
      for (int i = 0; i < SNIFF_NUM_CODES; i++) begin
         if (v[i]) begin
            exp_code_q.push_back(sniff_code_t'(i));
            exp_last_q.push_back(i == last);
            exp_test_q.push_back(test_name);
         end
      end
      if (last >= 0) begin
         vec_pending++;
      end
   endtask

   // One DUT cycle and its model step
   // A low keep leaves the vector out of the expectations
   task automatic apply(input c0_req_t c0, input c1_req_t c1, input mmio_evt_t mq,
                        input mmio_evt_t mr, input logic c0f, input logic c1f, input bit keep);
      sniff_vec_t v;
      @(posedge clk);
      c0_req   <= c0;
      c1_req   <= c1;
      mmio_req <= mq;
      mmio_rsp <= mr;
      c0_full  <= c0f;
      c1_full  <= c1f;
      v = expected_vector(c0, c1, mq, mr, c0f, c1f);
      if (keep) begin
         queue_codes(v);
      end
   endtask

   // Idles until at most level vectors are pending
   task automatic wait_below(input int level);
      int n;
      n = 0;
      while ((vec_pending > level) && !timed_out) begin
         apply('0, '0, '0, '0, 1'b0, 1'b0, 1'b1);
         n++;
         if (n > 4000) begin
            timed_out = 1'b1;
            errors++;
            $display("Timeout in %s: error codes stopped leaving the DUT", test_name);
         end
      end
   endtask

   // Keeps the FIFO clear of overflow
   task automatic send(input c0_req_t c0, input c1_req_t c1, input mmio_evt_t mq,
                       input mmio_evt_t mr, input logic c0f, input logic c1f);
      wait_below(SNIFF_FIFO_DEPTH - 2);
      apply(c0, c1, mq, mr, c0f, c1f, 1'b1);
   endtask

   task automatic send_c0(input ccip_req_t t, input cl_len_t len,
                          input logic [CL_ADDR_WIDTH-1:0] a, input logic full);
      send(rd_req(t, len, a), '0, '0, '0, full, 1'b0);
   endtask

   task automatic send_c1(input ccip_req_t t, input cl_len_t len, input logic sop,
                          input logic [CL_ADDR_WIDTH-1:0] a, input logic full);
      send('0, wr_req(t, len, sop, a), '0, '0, 1'b0, full);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         send('0, '0, '0, '0, 1'b0, 1'b0);
      end
   endtask

   // Checks each accepted code against the model queue
   always @(negedge clk) begin
      if (!ase_reset) begin
         if (stalled && (!err_valid || (err_code != stall_code))) begin
            errors++;
            $display("err_code left %s before err_ready took it", stall_code.name());
         end
         if (err_valid && err_ready) begin
            if (exp_code_q.size() == 0) begin
               errors++;
               $display("DUT emitted %s while no code was expected", err_code.name());
            end else begin
               exp_code = exp_code_q.pop_front();
               exp_last = exp_last_q.pop_front();
               exp_test = exp_test_q.pop_front();
               checks++;
               if (err_code != exp_code) begin
                  errors++;
                  $display("MISMATCH %s expected %s actual %s", exp_test,
                           exp_code.name(), err_code.name());
               end
               if (exp_last) begin
                  vec_pending--;
               end
            end
         end
         stalled    = err_valid && !err_ready;
         stall_code = err_code;
      end
   end

   initial begin
      c0_req_t rc0;
      c1_req_t rc1;
      clear_model();
      repeat (5) @(posedge clk);
      ase_reset <= 1'b0;

      // Every length, type and address mix on channel 0
      test_name = "c0_checks";
      for (int t = 0; t < 5; t++) begin
         for (int l = 0; l < 4; l++) begin
            for (int a = 0; a < 4; a++) begin
               send_c0(c0_types[t], cl_len_t'(l), c0_addrs[a], ((t + l + a) % 5) == 0);
            end
         end
      end

      test_name = "c1_good_bursts";
      send_c1(WRLINE_I, LEN_1CL, 1'b1, 42'h100, 1'b0);
      send_c1(WRLINE_M, LEN_2CL, 1'b1, 42'h102, 1'b0);
      send_c1(WRLINE_M, LEN_2CL, 1'b0, 42'h103, 1'b0);
      send_c1(WRFENCE, LEN_1CL, 1'b0, 42'h0, 1'b0);
      for (int b = 0; b < 4; b++) begin
         send_c1(WRPUSH_I, LEN_4CL, b == 0, 42'h104 + CL_ADDR_WIDTH'(b), 1'b0);
      end

      test_name = "c1_sop_errors";
      send_c1(WRLINE_I, LEN_1CL, 1'b0, 42'h110, 1'b0);
      send_c1(WRLINE_I, LEN_4CL, 1'b0, 42'h114, 1'b0);
      send_c1(WRLINE_I, LEN_2CL, 1'b1, 42'h120, 1'b0);
      send_c1(WRLINE_I, LEN_2CL, 1'b1, 42'h121, 1'b0);

      // Fence lands after the second beat
      test_name = "c1_fence_in_burst";
      for (int b = 0; b < 4; b++) begin
         send_c1(WRLINE_M, LEN_4CL, b == 0, 42'h124 + CL_ADDR_WIDTH'(b), 1'b0);
         if (b == 1) begin
            send_c1(WRFENCE, LEN_1CL, 1'b0, 42'h0, 1'b0);
         end
      end

      test_name = "c1_type_len_align";
      send_c1(WRLINE_I, LEN_2CL, 1'b1, 42'h130, 1'b0);
      send_c1(WRLINE_M, LEN_2CL, 1'b0, 42'h131, 1'b0);
      send_c1(WRLINE_I, LEN_3CL, 1'b1, 42'h134, 1'b0);
      send_c1(WRLINE_I, LEN_2CL, 1'b1, 42'h141, 1'b0);
      send_c1(WRLINE_I, LEN_2CL, 1'b0, 42'h142, 1'b0);
      for (int b = 0; b < 4; b++) begin
         send_c1(WRPUSH_I, LEN_4CL, b == 0, 42'h146 + CL_ADDR_WIDTH'(b), b == 2);
      end
      send_c1(WRLINE_I, LEN_1CL, 1'b1, 42'h150, 1'b1);
      send_c1(RDLINE_I, LEN_1CL, 1'b1, 42'h151, 1'b0);
      send_c1(WRLINE_M, LEN_1CL, 1'b1, 42'h0, 1'b0);

      test_name = "mmio_match";
      send('0, '0, evt(1'b1, 4'd2), '0, 1'b0, 1'b0);
      idle(3);
      send('0, '0, '0, evt(1'b1, 4'd2), 1'b0, 1'b0);
      test_name = "mmio_unsolicited";
      send('0, '0, '0, evt(1'b1, 4'd5), 1'b0, 1'b0);
      // Late response after the timeout stays quiet
      test_name = "mmio_timeout";
      send('0, '0, evt(1'b1, 4'd7), '0, 1'b0, 1'b0);
      idle(MMIO_RSP_TIMEOUT + 6);
      send('0, '0, '0, evt(1'b1, 4'd7), 1'b0, 1'b0);

      // Codes from all three checkers in one cycle
      test_name = "ordering";
      send(rd_req(WRLINE_I, LEN_1CL, 42'h0), wr_req(WRLINE_M, LEN_3CL, 1'b1, 42'h1),
           '0, evt(1'b1, 4'd9), 1'b1, 1'b1);
      send_c0(RDLINE_S, LEN_2CL, 42'h3, 1'b0);

      test_name = "random_traffic";
      for (int k = 0; k < 200; k++) begin
         // Fields are drawn at the falling edge
         @(negedge clk);
         rc0 = rd_req(c0_types[rnd(5)], cl_len_t'(rnd(4)), CL_ADDR_WIDTH'(rnd(8)));
         rc0.valid = (rnd(3) != 0);
         rc1 = wr_req(c1_types[rnd(5)], cl_len_t'(rnd(4)), rnd(4) != 0,
                      CL_ADDR_WIDTH'(rnd(8)));
         rc1.valid = (rnd(3) != 0);
         send(rc0, rc1, '0, evt(rnd(8) == 0, MMIO_TID_WIDTH'(rnd(16))),
              rnd(8) == 0, rnd(8) == 0);
      end

      // Fill the FIFO with ready low and send one vector too many
      test_name = "overflow";
      wait_below(0);
      @(negedge clk);
      if (lost_events !== 1'b0) begin
         errors++;
         $display("lost_events was set before the FIFO could overflow");
      end
      hold_low <= 1'b1;
      apply('0, '0, '0, '0, 1'b0, 1'b0, 1'b1);
      apply('0, '0, '0, '0, 1'b0, 1'b0, 1'b1);
      for (int k = 0; k <= SNIFF_FIFO_DEPTH; k++) begin
         apply(rd_req(WRFENCE, LEN_1CL, CL_ADDR_WIDTH'(k + 1)), '0, '0, '0,
               k == SNIFF_FIFO_DEPTH, 1'b0, k < SNIFF_FIFO_DEPTH);
      end
      repeat (3) begin
         apply('0, '0, '0, '0, 1'b0, 1'b0, 1'b1);
      end
      @(negedge clk);
      if (lost_events !== 1'b1) begin
         errors++;
         $display("lost_events stayed low after a vector met a full FIFO");
      end
      hold_low <= 1'b0;

      test_name = "final_drain";
      wait_below(0);
      idle(5);
      if (exp_code_q.size() != 0) begin
         errors++;
         $display("%0d expected codes never left the DUT", exp_code_q.size());
      end
      $display("checks=%0d errors=%0d pending_codes=%0d", checks, errors, exp_code_q.size());
      if ((errors == 0) && !timed_out) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/ccip_sniffer.sv */
// ***********************************************************
// CCI-P transmit protocol checker top level
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module ccip_sniffer
   import sniff_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       ase_reset,
   // Observed traffic, no back-pressure
   input  wire c0_req_t    c0_req,
   input  wire c1_req_t    c1_req,
   input  wire mmio_evt_t  mmio_req,
   input  wire mmio_evt_t  mmio_rsp,
   input  wire logic       c0_full,
   input  wire logic       c1_full,
   // Error code stream
   input  wire logic       err_ready,
   output logic            err_valid,
   output sniff_code_t     err_code,
   output logic            lost_events
);

   sniff_vec_t c0_errs;
   sniff_vec_t c1_errs;
   sniff_vec_t mmio_errs;
   sniff_vec_t err_vec;
   sniff_vec_t head_vec;
   logic       head_valid;
   logic       head_ready;

   c0tx_read_checker u_c0_chk (
      .clk       (clk),
      .ase_reset (ase_reset),
      .c0_req    (c0_req),
      .c0_full   (c0_full),
      .c0_errs   (c0_errs)
   );

   c1tx_mcl_checker u_c1_chk (
      .clk       (clk),
      .ase_reset (ase_reset),
      .c1_req    (c1_req),
      .c1_full   (c1_full),
      .c1_errs   (c1_errs)
   );

   mmio_rsp_tracker u_mmio_trk (
      .clk       (clk),
      .ase_reset (ase_reset),
      .mmio_req  (mmio_req),
      .mmio_rsp  (mmio_rsp),
      .mmio_errs (mmio_errs)
   );

   // Checkers own disjoint bits
   assign err_vec = c0_errs | c1_errs | mmio_errs;

   err_fifo u_fifo (
      .clk         (clk),
      .ase_reset   (ase_reset),
      .err_vec     (err_vec),
      .head_ready  (head_ready),
      .head_vec    (head_vec),
      .head_valid  (head_valid),
      .lost_events (lost_events)
   );

   err_serializer u_ser (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .head_vec   (head_vec),
      .head_valid (head_valid),
      .err_ready  (err_ready),
      .head_ready (head_ready),
      .err_valid  (err_valid),
      .err_code   (err_code)
   );

endmodule

`default_nettype wire

/* verilog/err_serializer.sv */
// ***********************************************************
// Error serializer, one code per transfer, lowest bit first
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module err_serializer
   import sniff_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       ase_reset,
   input  wire sniff_vec_t head_vec,
   input  wire logic       head_valid,
   input  wire logic       err_ready,
   output logic            head_ready,
   output logic            err_valid,
   output sniff_code_t     err_code
);

   sniff_vec_t                  sent_mask;
   sniff_vec_t                  pending;
   sniff_vec_t                  code_bit;
   logic [SNIFF_CODE_WIDTH-1:0] code_idx;
   logic                        last_code;
   logic                        accept;

   // Bits of the head vector not yet handed out
   assign pending = head_valid ? (head_vec & ~sent_mask) : '0;

   // Lowest pending index wins
   always_comb begin
      code_idx = '0;
      for (int i = SNIFF_NUM_CODES - 1; i >= 0; i--) begin
         if (pending[i]) begin
            code_idx = SNIFF_CODE_WIDTH'(i);
         end
      end
   end

   assign code_bit  = {{(SNIFF_NUM_CODES - 1){1'b0}}, 1'b1} << code_idx;
   assign last_code = ((pending & ~code_bit) == '0);

   // Code stays put until taken since mask and head only move on accept
   assign err_valid  = |pending;
   assign err_code   = sniff_code_t'(code_idx);
   assign accept     = err_valid && err_ready;
   // Pops the FIFO on the edge the last code leaves
   assign head_ready = accept && last_code;

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         sent_mask <= '0;
      end else if (accept) begin
         sent_mask <= last_code ? '0 : (sent_mask | code_bit);
      end
   end

endmodule

`default_nettype wire

/* verilog/err_fifo.sv */
// ***********************************************************
// Error vector FIFO, sticky flag on dropped vectors
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module err_fifo
   import sniff_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       ase_reset,
   input  wire sniff_vec_t err_vec,
   input  wire logic       head_ready,
   output sniff_vec_t      head_vec,
   output logic            head_valid,
   output logic            lost_events
);

   sniff_vec_t                 mem [SNIFF_FIFO_DEPTH];
   logic [SNIFF_PTR_WIDTH-1:0] wr_ptr;
   logic [SNIFF_PTR_WIDTH-1:0] rd_ptr;
   logic [SNIFF_CNT_WIDTH-1:0] count;
   logic                       full;
   logic                       push_req;
   logic                       push;
   logic                       pop;

   // Only cycles with at least one error are stored
   assign push_req = |err_vec;
   // Full is judged before a same-cycle pop
   assign full     = (count == SNIFF_CNT_WIDTH'(SNIFF_FIFO_DEPTH));
   assign push     = push_req && !full;
   assign pop      = head_valid && head_ready;

   assign head_valid = (count != '0);
   assign head_vec   = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= err_vec;
      end
   end

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         lost_events <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == SNIFF_PTR_WIDTH'(SNIFF_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == SNIFF_PTR_WIDTH'(SNIFF_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves count unchanged
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
         // Sticky until reset
         if (push_req && full) begin
            lost_events <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* sniff_checks/mmio_rsp_tracker.sv */
// ***********************************************************
// MMIO read tracker, flags unsolicited and late responses
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module mmio_rsp_tracker
   import sniff_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       ase_reset,
   input  wire mmio_evt_t  mmio_req,
   input  wire mmio_evt_t  mmio_rsp,
   output sniff_vec_t      mmio_errs
);

   logic [MMIO_NUM_TIDS-1:0]    active;
   logic [MMIO_TIMER_WIDTH-1:0] timer [MMIO_NUM_TIDS];
   logic [MMIO_NUM_TIDS-1:0]    req_hit;
   logic [MMIO_NUM_TIDS-1:0]    rsp_hit;
   logic [MMIO_NUM_TIDS-1:0]    expire;
   sniff_vec_t                  mmio_next;

   // Per-TID decode and expiry
   always_comb begin
      for (int i = 0; i < MMIO_NUM_TIDS; i++) begin
         req_hit[i] = mmio_req.valid && (mmio_req.tid == MMIO_TID_WIDTH'(i));
         rsp_hit[i] = mmio_rsp.valid && (mmio_rsp.tid == MMIO_TID_WIDTH'(i));
         // Timer steps onto the limit this edge
         expire[i]  = active[i] && !req_hit[i] && !rsp_hit[i] &&
                      (timer[i] == MMIO_TIMER_WIDTH'(MMIO_RSP_TIMEOUT - 1));
      end
   end

   always_comb begin
      mmio_next = '0;
      // Response with nothing outstanding on that TID
      mmio_next[MMIO_RDRSP_UNSOLICITED] = mmio_rsp.valid && !active[mmio_rsp.tid];
      mmio_next[MMIO_RDRSP_TIMEOUT] = |expire;
   end

   // Request wins over a response on the same TID
   always_ff @(posedge clk) begin
      if (ase_reset) begin
         active    <= '0;
         mmio_errs <= '0;
      end else begin
         for (int i = 0; i < MMIO_NUM_TIDS; i++) begin
            if (req_hit[i]) begin
               active[i] <= 1'b1;
            end else if (rsp_hit[i]) begin
               active[i] <= 1'b0;
            end
         end
         mmio_errs <= mmio_next;
      end
   end

   // Timers saturate at the limit so a timeout fires once
   // Entry stays active, late response clears it quietly
   always_ff @(posedge clk) begin
      for (int i = 0; i < MMIO_NUM_TIDS; i++) begin
         if (req_hit[i] || rsp_hit[i]) begin
            timer[i] <= '0;
         end else if (active[i] &&
                      (timer[i] != MMIO_TIMER_WIDTH'(MMIO_RSP_TIMEOUT))) begin
            timer[i] <= timer[i] + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* sniff_checks/c1tx_mcl_checker.sv */
// ***********************************************************
// Channel 1 write checker, follows multi-line write bursts
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module c1tx_mcl_checker
   import sniff_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       ase_reset,
   input  wire c1_req_t    c1_req,
   input  wire logic       c1_full,
   output sniff_vec_t      c1_errs
);

   // Which beat of a burst comes next
   typedef enum logic [1:0] {
      EXP_FIRST,
      EXP_2ND,
      EXP_3RD,
      EXP_4TH
   } burst_state_t;

   burst_state_t state;
   burst_state_t state_next;
   ccip_req_t    base_type;
   cl_len_t      base_len;
   sniff_vec_t   c1_next;
   logic         is_wr;
   logic         is_fence;
   logic         burst_start;

   assign is_wr    = c1_req.valid && is_write_req(c1_req.req_type);
   assign is_fence = c1_req.valid && (c1_req.req_type == WRFENCE);

   // Only a proper SOP beat of 2 or 4 lines opens a burst
   assign burst_start = (state == EXP_FIRST) && is_wr && c1_req.sop &&
                        (c1_req.cl_len inside {LEN_2CL, LEN_4CL});

   // Error bits
   always_comb begin
      c1_next = '0;
      if (c1_req.valid) begin
         c1_next[C1TX_INVALID_REQTYPE] = !(is_write_req(c1_req.req_type) ||
                                           (c1_req.req_type == WRFENCE));
         c1_next[C1TX_OVERFLOW] = c1_full;
      end
      if (state == EXP_FIRST) begin
         if (is_wr) begin
            // Missing SOP, beat counted as single line
            c1_next[C1TX_SOP_NOT_SET] = !c1_req.sop;
            c1_next[C1TX_3CL_REQUEST] = (c1_req.cl_len == LEN_3CL);
            c1_next[C1TX_ADDRALIGN_2] = misalign_2cl(c1_req.cl_len, c1_req.address[1:0]);
            c1_next[C1TX_ADDRALIGN_4] = misalign_4cl(c1_req.cl_len, c1_req.address[1:0]);
            c1_next[C1TX_ADDR_ZERO_WARN] = (c1_req.address == '0);
         end
      end else begin
         // Later beats must not carry SOP
         c1_next[C1TX_SOP_SET_MCL1TO3] = c1_req.valid && c1_req.sop;
         // Fence cannot split a burst
         c1_next[C1TX_WRFENCE_IN_MCL1TO3] = is_fence;
         // Type must match the SOP beat
         c1_next[C1TX_UNEXP_REQTYPE] = is_wr && (c1_req.req_type != base_type);
      end
   end

   // Burst sequencing, fences and bad types hold the state
   always_comb begin
      state_next = state;
      case (state)
         EXP_FIRST: begin
            if (burst_start) begin
               state_next = EXP_2ND;
            end
         end
         EXP_2ND: begin
            if (is_wr) begin
               state_next = (base_len == LEN_4CL) ? EXP_3RD : EXP_FIRST;
            end
         end
         EXP_3RD: begin
            if (is_wr) begin
               state_next = EXP_4TH;
            end
         end
         EXP_4TH: begin
            if (is_wr) begin
               state_next = EXP_FIRST;
            end
         end
         default: begin
            state_next = EXP_FIRST;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         state   <= EXP_FIRST;
         c1_errs <= '0;
      end else begin
         state   <= state_next;
         c1_errs <= c1_next;
      end
   end

   // Captured at SOP, only read while a burst is open
   always_ff @(posedge clk) begin
      if (burst_start) begin
         base_type <= c1_req.req_type;
         base_len  <= c1_req.cl_len;
      end
   end

endmodule

`default_nettype wire

/* sniff_checks/c0tx_read_checker.sv */
// ***********************************************************
// Channel 0 read request checker, one error bit per rule
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module c0tx_read_checker
   import sniff_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       ase_reset,
   input  wire c0_req_t    c0_req,
   input  wire logic       c0_full,
   output sniff_vec_t      c0_errs
);

   sniff_vec_t c0_next;
   logic       is_rd;

   // Length and address rules only apply to real reads
   assign is_rd = c0_req.valid && is_read_req(c0_req.req_type);

   always_comb begin
      c0_next = '0;
      if (c0_req.valid) begin
         // Anything other than RDLINE_S or RDLINE_I
         c0_next[C0TX_INVALID_REQTYPE] = !is_read_req(c0_req.req_type);
         // Issued while channel almost full
         c0_next[C0TX_OVERFLOW] = c0_full;
      end
      if (is_rd) begin
         // 3-line reads do not exist on CCI-P
         c0_next[C0TX_3CL_REQUEST] = (c0_req.cl_len == LEN_3CL);
         // Multi-line alignment
         c0_next[C0TX_ADDRALIGN_2] = misalign_2cl(c0_req.cl_len, c0_req.address[1:0]);
         c0_next[C0TX_ADDRALIGN_4] = misalign_4cl(c0_req.cl_len, c0_req.address[1:0]);
         // Zero address, warning only
         c0_next[C0TX_ADDR_ZERO_WARN] = (c0_req.address == '0);
      end
   end

   // Registered once per cycle
   always_ff @(posedge clk) begin
      if (ase_reset) begin
         c0_errs <= '0;
      end else begin
         c0_errs <= c0_next;
      end
   end

endmodule

`default_nettype wire

/* common/sniff_pkg.sv */
// ***********************************************************
// CCI-P sniffer shared types, widths and request helpers
// ***********************************************************
`default_nettype none

package sniff_pkg;

   // Cache-line address width
   localparam int CL_ADDR_WIDTH = 42;

   // MMIO transaction ID width, one tracker per TID
   localparam int MMIO_TID_WIDTH = 4;
   localparam int MMIO_NUM_TIDS = 2 ** MMIO_TID_WIDTH;

   // Cycles an MMIO read may stay outstanding
   localparam int MMIO_RSP_TIMEOUT = 64;
   localparam int MMIO_TIMER_WIDTH = $clog2(MMIO_RSP_TIMEOUT + 1);

   // Error vector buffer
   localparam int SNIFF_FIFO_DEPTH = 8;
   localparam int SNIFF_PTR_WIDTH = $clog2(SNIFF_FIFO_DEPTH);
   localparam int SNIFF_CNT_WIDTH = $clog2(SNIFF_FIFO_DEPTH + 1);

   // Error codes
   localparam int SNIFF_NUM_CODES = 18;
   localparam int SNIFF_CODE_WIDTH = 5;

   // Unified request type, write encodings as on CCI-P channel 1
   // Reads moved to the upper half so both channels share one enum
   typedef enum logic [3:0] {
      WRLINE_I = 4'h0,
      WRLINE_M = 4'h1,
      WRPUSH_I = 4'h2,
      WRFENCE  = 4'h4,
      RDLINE_S = 4'h8,
      RDLINE_I = 4'h9
   } ccip_req_t;

   // Lines per request
   typedef enum logic [1:0] {
      LEN_1CL = 2'b00,
      LEN_2CL = 2'b01,
      LEN_3CL = 2'b10,
      LEN_4CL = 2'b11
   } cl_len_t;

   // Code value doubles as bit index in the error vector
   typedef enum logic [SNIFF_CODE_WIDTH-1:0] {
      C0TX_INVALID_REQTYPE,
      C0TX_OVERFLOW,
      C0TX_ADDRALIGN_2,
      C0TX_ADDRALIGN_4,
      C0TX_3CL_REQUEST,
      C0TX_ADDR_ZERO_WARN,
      C1TX_INVALID_REQTYPE,
      C1TX_OVERFLOW,
      C1TX_ADDRALIGN_2,
      C1TX_ADDRALIGN_4,
      C1TX_SOP_NOT_SET,
      C1TX_SOP_SET_MCL1TO3,
      C1TX_3CL_REQUEST,
      C1TX_WRFENCE_IN_MCL1TO3,
      C1TX_UNEXP_REQTYPE,
      C1TX_ADDR_ZERO_WARN,
      MMIO_RDRSP_TIMEOUT,
      MMIO_RDRSP_UNSOLICITED
   } sniff_code_t;

   // One bit per error code
   typedef logic [SNIFF_NUM_CODES-1:0] sniff_vec_t;

   // Channel 0 read request header
   typedef struct packed {
      logic                     valid;
      cl_len_t                  cl_len;
      ccip_req_t                req_type;
      logic [CL_ADDR_WIDTH-1:0] address;
   } c0_req_t;

   // Channel 1 write request header
   typedef struct packed {
      logic                     valid;
      logic                     sop;
      cl_len_t                  cl_len;
      ccip_req_t                req_type;
      logic [CL_ADDR_WIDTH-1:0] address;
   } c1_req_t;

   // MMIO read request or response event
   typedef struct packed {
      logic                      valid;
      logic [MMIO_TID_WIDTH-1:0] tid;
   } mmio_evt_t;

   function automatic logic is_read_req(input ccip_req_t t);
      return t inside {RDLINE_S, RDLINE_I};
   endfunction

   function automatic logic is_write_req(input ccip_req_t t);
      return t inside {WRLINE_M, WRLINE_I, WRPUSH_I};
   endfunction

   // 2-line request must start on an even line
   function automatic logic misalign_2cl(input cl_len_t len, input logic [1:0] addr_lo);
      return (len == LEN_2CL) && addr_lo[0];
   endfunction

   // 4-line request must start on a 4-line boundary
   function automatic logic misalign_4cl(input cl_len_t len, input logic [1:0] addr_lo);
      return (len == LEN_4CL) && (addr_lo != 2'b00);
   endfunction

endpackage

`default_nettype wire
